/* src/rd_route_bus_pkg.sv */
// Bus-side widths, counts and address-window type for the read router
// Window bounds are inclusive on both ends
// slave_idx_t must be widened by hand if N_SLAVES grows past four

package rd_route_bus_pkg;

    // ============================================================
    // Fabric dimensions
    // ============================================================

    localparam int ADDR_W    = 32;
    localparam int N_SLAVES  = 4;
    localparam int N_MASTERS = 2;

    // ============================================================
    // Vector types
    // ============================================================

    // Shared read address
    typedef logic [ADDR_W-1:0] addr_t;

    // Slave number, used for the address and data mux selects
    typedef logic [1:0] slave_idx_t;

    // Owner code reported per slave; master 0 is 0, master 1 is 1
    typedef logic [1:0] master_id_t;

    // ============================================================
    // Address window
    // ============================================================

    // One slave's decode range, base <= addr <= limit
    typedef struct packed {
        addr_t base;
        addr_t limit;
    } addr_window_t;

endpackage

/* src/rd_route_ctrl_pkg.sv */
// Controller-side FSM states and the structs passed between
// arbiter, trackers and the owner merge

package rd_route_ctrl_pkg;

    // Address channel arbiter
    typedef enum logic [1:0] {
        ARB_IDLE     = 2'd0,
        ARB_GRANT_M0 = 2'd1,
        ARB_GRANT_M1 = 2'd2
    } arb_state_e;

    // Per-master read data tracker
    typedef enum logic {
        TRK_IDLE = 1'b0,
        TRK_BUSY = 1'b1
    } trk_state_e;

    // Single-cycle pulse to one tracker when its address is taken
    typedef struct packed {
        logic                         valid;
        rd_route_bus_pkg::slave_idx_t slave;
    } accept_t;

    // Slave a tracker is currently reading from
    typedef struct packed {
        logic                         active;
        rd_route_bus_pkg::slave_idx_t slave;
    } route_t;

endpackage

/* src/addr_range_decoder.sv */
// Purely combinational window decode of the shared read address
// Overlapping windows resolve to the lowest slave number
// hit_slave is zero on a miss

`timescale 1ns/1ps

module addr_range_decoder #(
    parameter int N_SLAVES_P = rd_route_bus_pkg::N_SLAVES
) (
    input  rd_route_bus_pkg::addr_window_t [N_SLAVES_P-1:0] windows,
    input  rd_route_bus_pkg::addr_t                         m_addr,
    output logic                                            hit,
    output rd_route_bus_pkg::slave_idx_t                    hit_slave
);

    logic [N_SLAVES_P-1:0] in_window;

    // One range compare per slave
    always_comb begin
        for (int s = 0; s < N_SLAVES_P; s++) begin
            in_window[s] = (m_addr >= windows[s].base) && (m_addr <= windows[s].limit);
        end
    end

    // Walk from the top down so the lowest matching slave is the last write
    always_comb begin
        hit       = 1'b0;
        hit_slave = '0;
        for (int s = N_SLAVES_P - 1; s >= 0; s--) begin
            if (in_window[s]) begin
                hit       = 1'b1;
                hit_slave = rd_route_bus_pkg::slave_idx_t'(s);
            end
        end
    end

    // A hit taken while another window compare is unknown may name the
    // wrong slave to the address mux and the tracker latch
    always_comb begin
        a_hit_slave_known: assert final (!hit || !$isunknown(in_window))
            else $error("decoder hit with unknown slave index");
    end

endmodule

/* src/addr_channel_arbiter.sv */
// Fixed-priority arbiter for the shared read address channel
// Grant states exist for masters 0 and 1 only; master 0 wins ties
// A master with a burst still in flight is not granted

`timescale 1ns/1ps

module addr_channel_arbiter #(
    parameter int N_MASTERS_P = rd_route_bus_pkg::N_MASTERS,
    parameter int N_SLAVES_P  = rd_route_bus_pkg::N_SLAVES
) (
    input  logic                                         clkk,
    input  logic                                         resett,
    input  logic [N_MASTERS_P-1:0]                       ar_valid,
    input  logic                                         hit,
    input  rd_route_bus_pkg::slave_idx_t                 hit_slave,
    input  logic [N_SLAVES_P-1:0]                        s_ar_ready,
    input  logic [N_MASTERS_P-1:0]                       trk_busy,
    output rd_route_ctrl_pkg::accept_t [N_MASTERS_P-1:0] accept,
    output logic                                         select_master_address,
    output rd_route_bus_pkg::slave_idx_t                 select_slave_address
);

    rd_route_ctrl_pkg::arb_state_e state_q;
    rd_route_ctrl_pkg::arb_state_e state_d;

    logic [N_MASTERS_P-1:0] eligible;
    logic [N_MASTERS_P-1:0] acc_valid;
    logic                   gnt_idx;

    // Requests from masters whose tracker is free
    assign eligible = ar_valid & ~trk_busy;
    assign gnt_idx  = (state_q == rd_route_ctrl_pkg::ARB_GRANT_M1);

    // ============================================================
    // State register
    // ============================================================

    always_ff @(posedge clkk or negedge resett) begin
        if (!resett) begin
            state_q <= rd_route_ctrl_pkg::ARB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ============================================================
    // Next state and accept pulse
    // ============================================================

    always_comb begin
        state_d = state_q;
        accept  = '0;
        case (state_q)
            rd_route_ctrl_pkg::ARB_IDLE: begin
                // Misses never get a grant
                if (hit) begin
                    if (eligible[0]) begin
                        state_d = rd_route_ctrl_pkg::ARB_GRANT_M0;
                    end else if (eligible[1]) begin
                        state_d = rd_route_ctrl_pkg::ARB_GRANT_M1;
                    end
                end
            end
            rd_route_ctrl_pkg::ARB_GRANT_M0,
            rd_route_ctrl_pkg::ARB_GRANT_M1: begin
                if (!ar_valid[gnt_idx] || !hit) begin
                    // Address withdrawn or moved out of every window
                    state_d = rd_route_ctrl_pkg::ARB_IDLE;
                end else if (s_ar_ready[hit_slave]) begin
                    accept[gnt_idx].valid = 1'b1;
                    accept[gnt_idx].slave = hit_slave;
                    state_d               = rd_route_ctrl_pkg::ARB_IDLE;
                end
            end
            default: begin
                state_d = rd_route_ctrl_pkg::ARB_IDLE;
            end
        endcase
    end

    // Address mux selects; idle parks both at zero
    assign select_master_address = gnt_idx;
    assign select_slave_address  = (state_q == rd_route_ctrl_pkg::ARB_IDLE) ? '0 : hit_slave;

    always_comb begin
        for (int m = 0; m < N_MASTERS_P; m++) begin
            acc_valid[m] = accept[m].valid;
        end
    end

    // Tracker busy comes back from the tracker array
    a_accept_free_trk: assert property (@(posedge clkk) disable iff (!resett)
        (acc_valid & trk_busy) == '0);

endmodule

/* src/master_read_tracker.sv */
// Follows one master's read burst from address accept to last beat
// Only one burst per master is outstanding at a time
// select_data and route are zero while idle

`timescale 1ns/1ps

module master_read_tracker #(
    parameter int N_SLAVES_P = rd_route_bus_pkg::N_SLAVES
) (
    input  logic                         clkk,
    input  logic                         resett,
    input  rd_route_ctrl_pkg::accept_t   accept,
    input  logic                         r_ready,
    input  logic [N_SLAVES_P-1:0]        s_r_valid,
    input  logic [N_SLAVES_P-1:0]        s_r_last,
    output rd_route_ctrl_pkg::route_t    route,
    output logic                         busy,
    output rd_route_bus_pkg::slave_idx_t select_data
);

    rd_route_ctrl_pkg::trk_state_e state_q;
    rd_route_bus_pkg::slave_idx_t  slave_q;

    logic beat;
    logic last_beat;

    // Beat handshake on the routed slave's data channel
    assign beat      = r_ready && s_r_valid[slave_q];
    assign last_beat = beat && s_r_last[slave_q];

    always_ff @(posedge clkk or negedge resett) begin
        if (!resett) begin
            state_q <= rd_route_ctrl_pkg::TRK_IDLE;
        end else begin
            case (state_q)
                rd_route_ctrl_pkg::TRK_IDLE: begin
                    if (accept.valid) begin
                        state_q <= rd_route_ctrl_pkg::TRK_BUSY;
                    end
                end
                rd_route_ctrl_pkg::TRK_BUSY: begin
                    if (last_beat) begin
                        state_q <= rd_route_ctrl_pkg::TRK_IDLE;
                    end
                end
                default: state_q <= rd_route_ctrl_pkg::TRK_IDLE;
            endcase
        end
    end

    // Slave number captured with the accept
    always_ff @(posedge clkk) begin
        if (accept.valid) begin
            slave_q <= accept.slave;
        end
    end

    assign busy         = (state_q == rd_route_ctrl_pkg::TRK_BUSY);
    assign select_data  = busy ? slave_q : '0;
    assign route.active = busy;
    assign route.slave  = select_data;

    // The arbiter must hold off this master until its burst has ended
    a_no_accept_busy: assert property (@(posedge clkk) disable iff (!resett)
        accept.valid |-> (state_q == rd_route_ctrl_pkg::TRK_IDLE));

endmodule

/* src/slave_owner_merge.sv */
// Per-slave owner code from the tracker routes
// The highest-numbered master routed to a slave wins
// Slaves nobody reads from report code zero

`timescale 1ns/1ps

module slave_owner_merge #(
    parameter int N_MASTERS_P = rd_route_bus_pkg::N_MASTERS,
    parameter int N_SLAVES_P  = rd_route_bus_pkg::N_SLAVES
) (
    input  rd_route_ctrl_pkg::route_t [N_MASTERS_P-1:0]  routes,
    output rd_route_bus_pkg::master_id_t [N_SLAVES_P-1:0] en_slave
);

    always_comb begin
        en_slave = '0;
        for (int s = 0; s < N_SLAVES_P; s++) begin
            // Ascending walk, so a later master overrides an earlier one
            for (int m = 0; m < N_MASTERS_P; m++) begin
                if (routes[m].active &&
                    (routes[m].slave == rd_route_bus_pkg::slave_idx_t'(s))) begin
                    en_slave[s] = rd_route_bus_pkg::master_id_t'(m);
                end
            end
        end
    end

endmodule

/* src/rd_route_ctrl.sv */
// Read-path routing controller for two masters and four slaves
// Windows are expected static while traffic runs
// Address mux select comes from the arbiter, data selects from the trackers

`timescale 1ns/1ps

module rd_route_ctrl #(
    parameter int N_MASTERS_P = rd_route_bus_pkg::N_MASTERS,
    parameter int N_SLAVES_P  = rd_route_bus_pkg::N_SLAVES
) (
    input  logic                                            clkk,
    input  logic                                            resett,
    input  rd_route_bus_pkg::addr_window_t [N_SLAVES_P-1:0] windows,
    input  rd_route_bus_pkg::addr_t                         m_addr,
    input  logic [N_MASTERS_P-1:0]                          ar_valid,
    input  logic [N_SLAVES_P-1:0]                           s_ar_ready,
    input  logic [N_SLAVES_P-1:0]                           s_r_valid,
    input  logic [N_SLAVES_P-1:0]                           s_r_last,
    input  logic [N_MASTERS_P-1:0]                          m_r_ready,
    output rd_route_bus_pkg::slave_idx_t                    select_slave_address,
    output logic                                            select_master_address,
    output rd_route_bus_pkg::slave_idx_t [N_MASTERS_P-1:0]  select_data,
    output rd_route_bus_pkg::master_id_t [N_SLAVES_P-1:0]   en_slave
);

    logic                                         hit;
    rd_route_bus_pkg::slave_idx_t                 hit_slave;
    rd_route_ctrl_pkg::accept_t [N_MASTERS_P-1:0] accept;
    rd_route_ctrl_pkg::route_t [N_MASTERS_P-1:0]  route;
    logic [N_MASTERS_P-1:0]                       trk_busy;

    // ============================================================
    // Address path
    // ============================================================

    addr_range_decoder #(
        .N_SLAVES_P (N_SLAVES_P)
    ) u_dec (
        .windows   (windows),
        .m_addr    (m_addr),
        .hit       (hit),
        .hit_slave (hit_slave)
    );

    addr_channel_arbiter #(
        .N_MASTERS_P (N_MASTERS_P),
        .N_SLAVES_P  (N_SLAVES_P)
    ) u_arb (
        .clkk                  (clkk),
        .resett                (resett),
        .ar_valid              (ar_valid),
        .hit                   (hit),
        .hit_slave             (hit_slave),
        .s_ar_ready            (s_ar_ready),
        .trk_busy              (trk_busy),
        .accept                (accept),
        .select_master_address (select_master_address),
        .select_slave_address  (select_slave_address)
    );

    // ============================================================
    // Data path, one tracker per master
    // ============================================================

    for (genvar i = 0; i < N_MASTERS_P; i++) begin : g_trk
        master_read_tracker #(
            .N_SLAVES_P (N_SLAVES_P)
        ) u_trk (
            .clkk        (clkk),
            .resett      (resett),
            .accept      (accept[i]),
            .r_ready     (m_r_ready[i]),
            .s_r_valid   (s_r_valid),
            .s_r_last    (s_r_last),
            .route       (route[i]),
            .busy        (trk_busy[i]),
            .select_data (select_data[i])
        );
    end

    slave_owner_merge #(
        .N_MASTERS_P (N_MASTERS_P),
        .N_SLAVES_P  (N_SLAVES_P)
    ) u_merge (
        .routes   (route),
        .en_slave (en_slave)
    );

endmodule

/* verification/tb_rd_route_ctrl.sv */
// Random traffic against a cycle model of the arbiter and trackers
// Windows are fixed with a gap at 0x3000..0x3fff and nothing above slave 3
// Inputs change 1 ns after the rising edge
// Outputs are compared on the falling edge

`timescale 1ns/1ps

module tb_rd_route_ctrl;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 3;
    localparam int N_PHASES     = 3;
    localparam int PHASE_CYCLES = 2000;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + N_PHASES * PHASE_CYCLES + 100) * CLK_PERIOD;
    localparam int NM           = rd_route_bus_pkg::N_MASTERS;
    localparam int NS           = rd_route_bus_pkg::N_SLAVES;

    logic                                    clkk;
    logic                                    resett;
    rd_route_bus_pkg::addr_window_t [NS-1:0] windows;
    rd_route_bus_pkg::addr_t                 m_addr;
    logic [NM-1:0]                           ar_valid;
    logic [NS-1:0]                           s_ar_ready;
    logic [NS-1:0]                           s_r_valid;
    logic [NS-1:0]                           s_r_last;
    logic [NM-1:0]                           m_r_ready;
    rd_route_bus_pkg::slave_idx_t            select_slave_address;
    logic                                    select_master_address;
    rd_route_bus_pkg::slave_idx_t [NM-1:0]   select_data;
    rd_route_bus_pkg::master_id_t [NS-1:0]   en_slave;

    // Window table used by both the DUT and the model
    rd_route_bus_pkg::addr_t win_base [NS];
    rd_route_bus_pkg::addr_t win_limit [NS];

    // Model state
    rd_route_ctrl_pkg::arb_state_e arb_q;
    logic [NM-1:0]                 busy_q;
    rd_route_bus_pkg::slave_idx_t  slave_q [NM];
    logic [NM-1:0]                 last_acc;

    // Per-phase traffic knobs in percent
    int p_req, p_miss, p_ardy, p_rvalid, p_last, p_rready;
    int slave_lo, slave_span;

    // Traffic statistics
    int n_accept, n_tie, n_both, n_shared, n_miss_req;

    rd_route_ctrl u_dut (
        .clkk                  (clkk),
        .resett                (resett),
        .windows               (windows),
        .m_addr                (m_addr),
        .ar_valid              (ar_valid),
        .s_ar_ready            (s_ar_ready),
        .s_r_valid             (s_r_valid),
        .s_r_last              (s_r_last),
        .m_r_ready             (m_r_ready),
        .select_slave_address  (select_slave_address),
        .select_master_address (select_master_address),
        .select_data           (select_data),
        .en_slave              (en_slave)
    );

    initial begin
        clkk = 1'b0;
        forever #(CLK_PERIOD / 2) clkk = ~clkk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired before the traffic phases completed");
        abort_run("watchdog timeout");
    end

    // ============================================================
    // Reporting and compare tasks
    // ============================================================

    task automatic abort_run(input string why);
        $display("Some tests failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_slave(input string name, input rd_route_bus_pkg::slave_idx_t exp,
                               input rd_route_bus_pkg::slave_idx_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
            abort_run("slave index mismatch");
        end
    endtask

    task automatic check_owner(input string name, input rd_route_bus_pkg::master_id_t exp,
                               input rd_route_bus_pkg::master_id_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
            abort_run("owner code mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t ns: %s expected %b, got %b", $time, name, exp, act);
            abort_run("single bit mismatch");
        end
    endtask

    // ============================================================
    // Cycle model
    // ============================================================

    // Lowest window holding the address or -1 on a miss
    function automatic int window_of(input rd_route_bus_pkg::addr_t a);
        for (int s = 0; s < NS; s++) begin
            if (a >= win_base[s] && a <= win_limit[s]) begin
                return s;
            end
        end
        return -1;
    endfunction

    task automatic compare_outputs();
        int                           d;
        rd_route_bus_pkg::slave_idx_t hs;
        rd_route_bus_pkg::master_id_t own;
        d  = window_of(m_addr);
        hs = (d < 0) ? '0 : rd_route_bus_pkg::slave_idx_t'(d);
        check_slave("select_slave_address", (arb_q == rd_route_ctrl_pkg::ARB_IDLE) ? '0 : hs,
                    select_slave_address);
        check_bit("select_master_address", arb_q == rd_route_ctrl_pkg::ARB_GRANT_M1,
                  select_master_address);
        for (int m = 0; m < NM; m++) begin
            check_slave($sformatf("select_data[%0d]", m), busy_q[m] ? slave_q[m] : '0,
                        select_data[m]);
        end
        for (int s = 0; s < NS; s++) begin
            own = '0;
            for (int m = 0; m < NM; m++) begin
                if (busy_q[m] && slave_q[m] == s) own = rd_route_bus_pkg::master_id_t'(m);
            end
            check_owner($sformatf("en_slave[%0d]", s), own, en_slave[s]);
        end
    endtask

    task automatic advance_model();
        int                           d;
        int                           g;
        rd_route_bus_pkg::slave_idx_t hs;
        logic [NM-1:0]                acc;
        d   = window_of(m_addr);
        hs  = (d < 0) ? '0 : rd_route_bus_pkg::slave_idx_t'(d);
        acc = '0;
        if (busy_q == 2'b11) n_both++;
        if (busy_q == 2'b11 && slave_q[0] == slave_q[1]) n_shared++;
        if (arb_q == rd_route_ctrl_pkg::ARB_IDLE) begin
            if (d >= 0) begin
                if (ar_valid == 2'b11 && busy_q == 2'b00) n_tie++;
                if (ar_valid[0] && !busy_q[0]) arb_q = rd_route_ctrl_pkg::ARB_GRANT_M0;
                else if (ar_valid[1] && !busy_q[1]) arb_q = rd_route_ctrl_pkg::ARB_GRANT_M1;
            end else if (ar_valid != '0) begin
                n_miss_req++;
            end
        end else begin
            g = (arb_q == rd_route_ctrl_pkg::ARB_GRANT_M1) ? 1 : 0;
            if (!ar_valid[g] || d < 0) begin
                arb_q = rd_route_ctrl_pkg::ARB_IDLE;
            end else if (s_ar_ready[hs]) begin
                acc[g] = 1'b1;
                arb_q  = rd_route_ctrl_pkg::ARB_IDLE;
                n_accept++;
            end
        end
        // Burst ends on a beat carrying last and an accept starts a new one
        for (int m = 0; m < NM; m++) begin
            if (busy_q[m]) begin
                if (m_r_ready[m] && s_r_valid[slave_q[m]] && s_r_last[slave_q[m]]) busy_q[m] = 0;
            end else if (acc[m]) begin
                busy_q[m]  = 1'b1;
                slave_q[m] = hs;
            end
        end
        last_acc = acc;
    endtask

    always @(negedge clkk) begin
        if (!resett) begin
            arb_q    = rd_route_ctrl_pkg::ARB_IDLE;
            busy_q   = '0;
            last_acc = '0;
        end
        compare_outputs();
        if (resett) advance_model();
    end

    // ============================================================
    // Stimulus
    // ============================================================

    function automatic logic chance(input int pct);
        return $urandom_range(99) < pct;
    endfunction

    function automatic rd_route_bus_pkg::addr_t random_addr();
        int s;
        if (chance(p_miss)) begin
            return chance(50) ? 32'h0000_3000 + $urandom_range(32'hfff) : 32'h8000_0000;
        end
        s = slave_lo + $urandom_range(slave_span - 1);
        case ($urandom_range(3))
            0: return win_base[s];
            1: return win_limit[s];
            default: return win_base[s] + $urandom_range(win_limit[s] - win_base[s]);
        endcase
    endfunction

    task automatic load_knobs(input int req, input int miss, input int ardy, input int rvalid,
                              input int rlast, input int rready, input int lo, input int span);
        p_req      = req;
        p_miss     = miss;
        p_ardy     = ardy;
        p_rvalid   = rvalid;
        p_last     = rlast;
        p_rready   = rready;
        slave_lo   = lo;
        slave_span = span;
    endtask

    task automatic set_phase(input int p);
        case (p)
            // Balanced traffic over all slaves
            0: load_knobs(40, 12, 50, 60, 35, 70, 0, 4);
            // Heavy back-pressure on both channels
            1: load_knobs(60, 10, 20, 40, 25, 35, 0, 4);
            // Two slaves only so both masters often share one
            default: load_knobs(70, 15, 60, 50, 20, 50, 2, 2);
        endcase
    endtask

    task automatic drive_inputs();
        for (int m = 0; m < NM; m++) begin
            if (last_acc[m]) ar_valid[m] = 1'b0;
            else if (ar_valid[m]) ar_valid[m] = !chance(5);
            else ar_valid[m] = chance(p_req);
            m_r_ready[m] = chance(p_rready);
        end
        if (last_acc != '0 || chance(8)) m_addr = random_addr();
        for (int s = 0; s < NS; s++) begin
            s_ar_ready[s] = chance(p_ardy);
            s_r_valid[s]  = chance(p_rvalid);
            s_r_last[s]   = chance(p_last);
        end
    endtask

    initial begin
        win_base[0] = 32'h0000_0000;
        win_limit[0] = 32'h0000_0fff;
        win_base[1] = 32'h0000_1000;
        win_limit[1] = 32'h0000_1fff;
        win_base[2] = 32'h0000_2000;
        win_limit[2] = 32'h0000_2fff;
        win_base[3] = 32'h0000_4000;
        win_limit[3] = 32'h0000_4fff;
        for (int s = 0; s < NS; s++) begin
            windows[s].base  = win_base[s];
            windows[s].limit = win_limit[s];
        end
        resett     = 1'b0;
        m_addr     = '0;
        ar_valid   = '0;
        s_ar_ready = '0;
        s_r_valid  = '0;
        s_r_last   = '0;
        m_r_ready  = '0;
        n_accept   = 0;
        n_tie      = 0;
        n_both     = 0;
        n_shared   = 0;
        n_miss_req = 0;
        void'($urandom(32'h9c058dec));
        repeat (RESET_CYCLES) @(posedge clkk);
        #1 resett = 1'b1;
        for (int p = 0; p < N_PHASES; p++) begin
            set_phase(p);
            repeat (PHASE_CYCLES) begin
                @(posedge clkk);
                #1;
                drive_inputs();
            end
        end
        repeat (2) @(negedge clkk);
        @(posedge clkk);
        if (n_accept == 0 || n_tie == 0 || n_both == 0 || n_shared == 0 || n_miss_req == 0) begin
            $display("Traffic missed a case: accepts %0d ties %0d both %0d shared %0d miss %0d",
                     n_accept, n_tie, n_both, n_shared, n_miss_req);
            abort_run("coverage of traffic cases incomplete");
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

/* rd_route_ctrl.f */
src/rd_route_bus_pkg.sv
src/rd_route_ctrl_pkg.sv
src/addr_range_decoder.sv
src/addr_channel_arbiter.sv
src/master_read_tracker.sv
src/slave_owner_merge.sv
src/rd_route_ctrl.sv
verification/tb_rd_route_ctrl.sv

/* Bender.yml */
package:
  name: rd_route_ctrl

dependencies: {}

sources:
  # Packages first, the RTL depends on them
  - src/rd_route_bus_pkg.sv
  - src/rd_route_ctrl_pkg.sv
  - src/addr_range_decoder.sv
  - src/addr_channel_arbiter.sv
  - src/master_read_tracker.sv
  - src/slave_owner_merge.sv
  - src/rd_route_ctrl.sv
  - target: test
    files:
      - verification/tb_rd_route_ctrl.sv
